/* hdl/serial_link_macros.svh */
////////////////////////////////////////
// Serial link data link parameters
// Channel count, widths and FIFO depths
////////////////////////////////////////

`ifndef SERIAL_LINK_MACROS_SVH
`define SERIAL_LINK_MACROS_SVH

// Physical channels and bits per channel
`define SL_NUM_CHANNELS 2
`define SL_PHY_WIDTH 8

// Payload carried by the stream interface
`define SL_PAYLOAD_WIDTH 32

// Flow control and raw mode buffering
`define SL_RECV_FIFO_DEPTH 4
`define SL_RAW_FIFO_DEPTH 8

// One beat covers all channels at once
`define SL_BEAT_WIDTH (`SL_NUM_CHANNELS * `SL_PHY_WIDTH)
`define SL_NUM_SPLITS (`SL_PAYLOAD_WIDTH / `SL_BEAT_WIDTH)

`endif

/* hdl/serial_link_pkg.sv */
////////////////////////////////////////
// Serial link types
// Vector typedefs and the send FSM states
////////////////////////////////////////

`default_nettype none

`include "serial_link_macros.svh"

package serial_link_pkg;

  // One byte on one channel
  typedef logic [`SL_PHY_WIDTH-1:0] phy_data_t;

  // All channels side by side, channel i at bits 8i+7:8i
  typedef logic [`SL_BEAT_WIDTH-1:0] beat_t;

  typedef logic [`SL_PAYLOAD_WIDTH-1:0] payload_t;

  // Per channel flags and channel index
  typedef logic [`SL_NUM_CHANNELS-1:0] chan_mask_t;
  typedef logic [$clog2(`SL_NUM_CHANNELS)-1:0] chan_sel_t;

  // Wraps to 0 when the raw FIFO is full
  typedef logic [$clog2(`SL_RAW_FIFO_DEPTH)-1:0] raw_fill_t;

  typedef enum logic {
    LINK_SEND_IDLE,
    LINK_SEND_BUSY
  } link_state_e;

endpackage

`default_nettype wire

/* hdl/serial_link_tx_split.sv */
////////////////////////////////////////
// Transmit splitter
// Cuts a payload into beats, low beat first
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "serial_link_macros.svh"

module serial_link_tx_split
  import serial_link_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  // Payload stream
  input  payload_t payload_i,
  input  logic     payload_valid_i,
  output logic     payload_ready_o,
  // Beat towards the channels
  output beat_t    beat_o,
  output logic     beat_valid_o,
  input  logic     beat_ready_i
);

  localparam int BEAT_W     = `SL_BEAT_WIDTH;
  localparam int NUM_SPLITS = `SL_NUM_SPLITS;
  localparam int IDX_W      = (NUM_SPLITS > 1) ? $clog2(NUM_SPLITS) : 1;

  link_state_e      state_q, state_d;
  logic [IDX_W-1:0] beat_idx_q, beat_idx_d;

  ////////////////////////////////////////
  // Send FSM
  ////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    beat_idx_d      = beat_idx_q;
    beat_o          = '0;
    beat_valid_o    = 1'b0;
    payload_ready_o = 1'b0;

    unique case (state_q)
      LINK_SEND_IDLE: begin
        // First beat goes out in the same cycle as the payload
        if (payload_valid_i) begin
          beat_valid_o = 1'b1;
          beat_o       = payload_i[BEAT_W-1:0];
          if (beat_ready_i) begin
            state_d    = LINK_SEND_BUSY;
            beat_idx_d = IDX_W'(1);
          end
        end
      end

      LINK_SEND_BUSY: begin
        beat_valid_o = 1'b1;
        beat_o       = payload_i[beat_idx_q*BEAT_W +: BEAT_W];
        if (beat_ready_i) begin
          if (beat_idx_q == IDX_W'(NUM_SPLITS - 1)) begin
            // Last beat taken, release the payload
            payload_ready_o = 1'b1;
            state_d         = LINK_SEND_IDLE;
            beat_idx_d      = '0;
          end else begin
            beat_idx_d = beat_idx_q + 1'b1;
          end
        end
      end

      default: begin
        state_d = LINK_SEND_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= LINK_SEND_IDLE;
      beat_idx_q <= '0;
    end else begin
      state_q    <= state_d;
      beat_idx_q <= beat_idx_d;
    end
  end

  // Upstream must hold the payload while a beat is stalled
  payload_stable_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    beat_valid_o && !beat_ready_i |=> $stable(payload_i)
  );

endmodule

`default_nettype wire

/* hdl/serial_link_rx_assemble.sv */
////////////////////////////////////////
// Receive assembler
// Flow control FIFO plus split registers
// that rebuild a payload from beats
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "serial_link_macros.svh"

module serial_link_rx_assemble
  import serial_link_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       clear_i,
  // Beats from the channels
  input  beat_t      beat_i,
  input  chan_mask_t beat_valid_i,
  output chan_mask_t beat_ready_o,
  // Rebuilt payload
  output payload_t   payload_o,
  output logic       payload_valid_o,
  input  logic       payload_ready_i
);

  localparam int NUM_CH     = `SL_NUM_CHANNELS;
  localparam int NUM_SPLITS = `SL_NUM_SPLITS;
  localparam int DEPTH      = `SL_RECV_FIFO_DEPTH;
  localparam int PTR_W      = $clog2(DEPTH);
  localparam int IDX_W      = (NUM_SPLITS > 1) ? $clog2(NUM_SPLITS) : 1;

  beat_t            fifo_mem [DEPTH];
  logic [PTR_W-1:0] fifo_wr_ptr_q, fifo_rd_ptr_q;
  logic [PTR_W:0]   fifo_count_q;
  logic             fifo_full, fifo_empty;
  logic             fifo_push, fifo_pop;

  beat_t [NUM_SPLITS-1:0] split_data_q;
  logic  [NUM_SPLITS-1:0] split_full_q;
  logic  [IDX_W-1:0]      split_idx_q;
  logic                   payload_fire;

  ////////////////////////////////////////
  // Flow control FIFO
  ////////////////////////////////////////

  assign fifo_full  = (fifo_count_q == (PTR_W+1)'(DEPTH));
  assign fifo_empty = (fifo_count_q == '0);

  // A beat counts only when every channel has one
  assign fifo_push    = (&beat_valid_i) && !fifo_full;
  assign beat_ready_o = {NUM_CH{fifo_push}};

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fifo_wr_ptr_q <= '0;
      fifo_rd_ptr_q <= '0;
      fifo_count_q  <= '0;
    end else if (clear_i) begin
      fifo_wr_ptr_q <= '0;
      fifo_rd_ptr_q <= '0;
      fifo_count_q  <= '0;
    end else begin
      if (fifo_push) begin
        fifo_wr_ptr_q <= fifo_wr_ptr_q + 1'b1;
      end
      if (fifo_pop) begin
        fifo_rd_ptr_q <= fifo_rd_ptr_q + 1'b1;
      end
      if (fifo_push && !fifo_pop) begin
        fifo_count_q <= fifo_count_q + 1'b1;
      end else if (!fifo_push && fifo_pop) begin
        fifo_count_q <= fifo_count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fifo_push) begin
      fifo_mem[fifo_wr_ptr_q] <= beat_i;
    end
  end

  ////////////////////////////////////////
  // Split registers
  ////////////////////////////////////////

  assign payload_valid_o = &split_full_q;
  assign payload_fire    = payload_valid_o && payload_ready_i;
  assign payload_o       = split_data_q;

  // Current split frees up in the same cycle the payload leaves
  assign fifo_pop = !fifo_empty && (!split_full_q[split_idx_q] || payload_fire);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      split_full_q <= '0;
      split_idx_q  <= '0;
    end else if (clear_i) begin
      split_full_q <= '0;
      split_idx_q  <= '0;
    end else begin
      if (payload_fire) begin
        split_full_q <= '0;
      end
      if (fifo_pop) begin
        split_full_q[split_idx_q] <= 1'b1;
        split_idx_q <= (split_idx_q == IDX_W'(NUM_SPLITS - 1)) ? '0 : split_idx_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fifo_pop) begin
      split_data_q[split_idx_q] <= fifo_mem[fifo_rd_ptr_q];
    end
  end

  // A push into a full FIFO would run the count past the depth
  // or out of step with the pointers
  no_push_full_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    fifo_count_q <= (PTR_W+1)'(DEPTH)
      && fifo_count_q[PTR_W-1:0] == PTR_W'(fifo_wr_ptr_q - fifo_rd_ptr_q)
  );

  // Index points at the next free split, wrapping once all are full
  split_idx_range_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    int'(split_idx_q) == $countones(split_full_q) % NUM_SPLITS
  );

endmodule

`default_nettype wire

/* hdl/serial_link_raw_fifo.sv */
////////////////////////////////////////
// Raw mode transmit byte FIFO
// Circular buffer with fill level and clear
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "serial_link_macros.svh"

module serial_link_raw_fifo
  import serial_link_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      clear_i,
  input  logic      push_i,
  input  phy_data_t data_i,
  input  logic      pop_i,
  output phy_data_t data_o,
  output logic      empty_o,
  output logic      full_o,
  output raw_fill_t fill_o
);

  localparam int DEPTH = `SL_RAW_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  phy_data_t        mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             push;

  assign full_o  = (count_q == (PTR_W+1)'(DEPTH));
  assign empty_o = (count_q == '0);
  // Top bit dropped, full reads back as 0
  assign fill_o  = count_q[PTR_W-1:0];
  assign data_o  = mem[rd_ptr_q];

  // Pushes into a full FIFO are lost
  assign push = push_i && !full_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (!push && pop_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  // Caller gates pops with the empty flag
  no_pop_empty_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> !empty_o
  );

endmodule

`default_nettype wire

/* hdl/serial_link_data_link.sv */
////////////////////////////////////////
// Serial link data link layer
// Steers normal payload traffic or raw
// calibration bytes onto the channels
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "serial_link_macros.svh"

module serial_link_data_link
  import serial_link_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  // Payload streams
  input  payload_t   payload_in_i,
  input  logic       payload_in_valid_i,
  output logic       payload_in_ready_o,
  output payload_t   payload_out_o,
  output logic       payload_out_valid_o,
  input  logic       payload_out_ready_i,
  // Phy channels
  output beat_t      data_out_o,
  output chan_mask_t data_out_valid_o,
  input  logic       data_out_ready_i,
  input  beat_t      data_in_i,
  input  chan_mask_t data_in_valid_i,
  output chan_mask_t data_in_ready_o,
  // Raw mode and configuration
  input  logic       raw_mode_en_i,
  input  logic       recv_fifo_clear_i,
  input  chan_sel_t  raw_in_ch_sel_i,
  output phy_data_t  raw_in_data_o,
  output chan_mask_t raw_in_valid_o,
  input  logic       raw_in_ready_i,
  input  chan_mask_t raw_out_ch_mask_i,
  input  phy_data_t  raw_out_data_i,
  input  logic       raw_out_valid_i,
  input  logic       raw_out_en_i,
  input  logic       raw_fifo_clear_i,
  output raw_fill_t  raw_fill_o,
  output logic       raw_full_o
);

  localparam int NUM_CH = `SL_NUM_CHANNELS;
  localparam int PHY_W  = `SL_PHY_WIDTH;

  beat_t      tx_beat;
  logic       tx_beat_valid;
  chan_mask_t rx_beat_valid, rx_beat_ready;
  phy_data_t  raw_head;
  logic       raw_empty, raw_pop;

  ////////////////////////////////////////
  // Transmit path
  ////////////////////////////////////////

  serial_link_tx_split i_tx_split (
    .clk_i           ( clk_i                                 ),
    .rst_n_i         ( rst_n_i                               ),
    .payload_i       ( payload_in_i                          ),
    .payload_valid_i ( payload_in_valid_i && !raw_mode_en_i  ),
    .payload_ready_o ( payload_in_ready_o                    ),
    .beat_o          ( tx_beat                               ),
    .beat_valid_o    ( tx_beat_valid                         ),
    .beat_ready_i    ( data_out_ready_i && !raw_mode_en_i    )
  );

  serial_link_raw_fifo i_raw_fifo (
    .clk_i   ( clk_i            ),
    .rst_n_i ( rst_n_i          ),
    .clear_i ( raw_fifo_clear_i ),
    .push_i  ( raw_out_valid_i  ),
    .data_i  ( raw_out_data_i   ),
    .pop_i   ( raw_pop          ),
    .data_o  ( raw_head         ),
    .empty_o ( raw_empty        ),
    .full_o  ( raw_full_o       ),
    .fill_o  ( raw_fill_o       )
  );

  always_comb begin
    data_out_o       = '0;
    data_out_valid_o = '0;
    raw_pop          = 1'b0;
    if (raw_mode_en_i) begin
      // Head byte copied onto every channel, mask picks the live ones
      if (raw_out_en_i && !raw_empty) begin
        data_out_o       = {NUM_CH{raw_head}};
        data_out_valid_o = raw_out_ch_mask_i;
        raw_pop          = data_out_ready_i;
      end
    end else begin
      data_out_o       = tx_beat;
      data_out_valid_o = {NUM_CH{tx_beat_valid}};
    end
  end

  ////////////////////////////////////////
  // Receive path
  ////////////////////////////////////////

  assign rx_beat_valid = data_in_valid_i & {NUM_CH{!raw_mode_en_i}};

  serial_link_rx_assemble i_rx_assemble (
    .clk_i           ( clk_i               ),
    .rst_n_i         ( rst_n_i             ),
    .clear_i         ( recv_fifo_clear_i   ),
    .beat_i          ( data_in_i           ),
    .beat_valid_i    ( rx_beat_valid       ),
    .beat_ready_o    ( rx_beat_ready       ),
    .payload_o       ( payload_out_o       ),
    .payload_valid_o ( payload_out_valid_o ),
    .payload_ready_i ( payload_out_ready_i )
  );

  always_comb begin
    data_in_ready_o = rx_beat_ready;
    raw_in_data_o   = '0;
    raw_in_valid_o  = '0;
    if (raw_mode_en_i) begin
      data_in_ready_o = '0;
      raw_in_valid_o  = data_in_valid_i;
      raw_in_data_o   = data_in_i[raw_in_ch_sel_i*PHY_W +: PHY_W];
      // Read strobe only consumes a byte that is actually there
      if (raw_in_ready_i && data_in_valid_i[raw_in_ch_sel_i]) begin
        data_in_ready_o[raw_in_ch_sel_i] = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* tb/tb_serial_link_data_link.sv */
////////////////////////////////////////
// Data link testbench
// Random traffic in normal and raw mode,
// checked by assertions on expected queues
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "serial_link_macros.svh"

module tb_serial_link_data_link
  import serial_link_pkg::*;
();

  localparam int N_TX_PAYLOADS = 40;
  localparam int N_RX_PAYLOADS = 40;
  localparam int N_RAW_MIX     = 24;
  localparam int N_RAW_RX      = 32;
  localparam int RAW_DEPTH     = `SL_RAW_FIFO_DEPTH;
  // Last term covers reset, partial valid and the clear steps
  localparam int TOTAL_TRANSFERS = 2 * N_TX_PAYLOADS + 2 * N_RX_PAYLOADS + RAW_DEPTH + 1
                                 + N_RAW_MIX + N_RAW_RX + 32;
  localparam int TIMEOUT_CYCLES  = 20 * TOTAL_TRANSFERS;

  logic       clk_i = 1'b0;
  logic       rst_n_i;
  payload_t   payload_in_i, payload_out_o;
  logic       payload_in_valid_i, payload_in_ready_o;
  logic       payload_out_valid_o, payload_out_ready_i;
  beat_t      data_out_o, data_in_i;
  chan_mask_t data_out_valid_o, data_in_valid_i, data_in_ready_o;
  logic       data_out_ready_i;
  logic       raw_mode_en_i, recv_fifo_clear_i, raw_fifo_clear_i;
  chan_sel_t  raw_in_ch_sel_i;
  phy_data_t  raw_in_data_o, raw_out_data_i;
  chan_mask_t raw_in_valid_o, raw_out_ch_mask_i;
  logic       raw_in_ready_i, raw_out_valid_i, raw_out_en_i;
  raw_fill_t  raw_fill_o;
  logic       raw_full_o;

  int seed = 8;

  // Expected traffic, written at the producer side and read at the consumer side
  beat_t      exp_beat_mem [256];
  beat_t      rx_mem [256];
  phy_data_t  raw_mem [256];
  logic [7:0] tx_rd = '0, tx_wr = '0;
  logic [7:0] rx_rd = '0, rx_wr = '0;
  logic [7:0] raw_rd = '0, raw_wr = '0;
  logic [7:0] raw_count;
  logic       tx_accept, payload_fire;

  serial_link_data_link DUT (.*);

  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] next_random();
    next_random = $random(seed);
  endfunction

  task automatic stop_with_failure();
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic report_error(input string msg);
    $display("ERROR @ %0t ns: %s", $time, msg);
    stop_with_failure();
  endtask

  ////////////////////////////////////////
  // Reference models
  ////////////////////////////////////////

  assign tx_accept    = !raw_mode_en_i && data_out_valid_o == '1 && data_out_ready_i;
  assign payload_fire = payload_out_valid_o && payload_out_ready_i;
  assign raw_count    = raw_wr - raw_rd;

  always @(posedge clk_i) begin
    if (tx_accept) begin
      tx_rd <= tx_rd + 8'd1;
    end
  end

  always @(posedge clk_i) begin
    if (recv_fifo_clear_i) begin
      rx_rd <= rx_wr;
    end else begin
      if (!raw_mode_en_i && data_in_ready_o == '1) begin
        rx_mem[rx_wr] <= data_in_i;
        rx_wr         <= rx_wr + 8'd1;
      end
      if (payload_fire) begin
        rx_rd <= rx_rd + 8'd2;
      end
    end
  end

  // Byte FIFO model, a push into a full FIFO is lost
  always @(posedge clk_i) begin
    if (raw_fifo_clear_i) begin
      raw_rd <= raw_wr;
    end else begin
      if (raw_out_valid_i && raw_count != 8'(RAW_DEPTH)) begin
        raw_mem[raw_wr] <= raw_out_data_i;
        raw_wr          <= raw_wr + 8'd1;
      end
      if (raw_mode_en_i && raw_out_en_i && raw_count != 8'd0 && data_out_ready_i) begin
        raw_rd <= raw_rd + 8'd1;
      end
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  tx_beat_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tx_accept |-> tx_rd != tx_wr && data_out_o == exp_beat_mem[tx_rd]
  ) else report_error("transmit beat differs from the expected payload slice");

  tx_valid_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !raw_mode_en_i |-> data_out_valid_o == '0 || data_out_valid_o == '1
  ) else report_error("normal mode channel valids are not all equal");

  // Odd read index means the high slice is going out
  tx_release_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    payload_in_ready_o |-> tx_accept && tx_rd[0]
  ) else report_error("payload released before its last beat");

  tx_last_beat_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tx_accept && tx_rd[0] |-> payload_in_ready_o
  ) else report_error("payload not released with its last beat");

  rx_payload_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    payload_fire |-> (rx_wr - rx_rd) >= 8'd2
      && payload_out_o == {rx_mem[rx_rd + 8'd1], rx_mem[rx_rd]}
  ) else report_error("received payload differs from the pushed beats");

  rx_no_stale_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    payload_out_valid_o |-> (rx_wr - rx_rd) >= 8'd2
  ) else report_error("payload offered without two fresh beats");

  rx_partial_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !raw_mode_en_i && !(&data_in_valid_i) |-> data_in_ready_o == '0
  ) else report_error("beat accepted with only some channels valid");

  rx_clear_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    recv_fifo_clear_i |=> !payload_out_valid_o
  ) else report_error("payload still offered after a receive clear");

  raw_out_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    raw_mode_en_i && raw_out_en_i && raw_count != 8'd0
      |-> data_out_o == {`SL_NUM_CHANNELS{raw_mem[raw_rd]}}
      && data_out_valid_o == raw_out_ch_mask_i
  ) else report_error("raw byte or channel mask wrong on the phy output");

  raw_idle_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    raw_mode_en_i && (!raw_out_en_i || raw_count == 8'd0) |-> data_out_valid_o == '0
  ) else report_error("raw output valid without a byte to send");

  raw_fill_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    raw_fill_o == raw_fill_t'(raw_count) && raw_full_o == (raw_count == 8'(RAW_DEPTH))
  ) else report_error("raw FIFO fill level or full flag wrong");

  raw_in_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    raw_mode_en_i |-> raw_in_valid_o == data_in_valid_i
      && raw_in_data_o == (raw_in_ch_sel_i ? data_in_i[15:8] : data_in_i[7:0])
      && data_in_ready_o == ((raw_in_ready_i && data_in_valid_i[raw_in_ch_sel_i])
                             ? chan_mask_t'(1) << raw_in_ch_sel_i : '0)
  ) else report_error("raw receive byte, valid or ready wrong");

  raw_in_off_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !raw_mode_en_i |-> raw_in_data_o == '0 && raw_in_valid_o == '0
  ) else report_error("raw receive outputs active in normal mode");

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic send_payloads(input int count);
    payload_t value;
    for (int n = 0; n < count; n++) begin
      value = payload_t'(next_random());
      payload_in_i                 <= value;
      payload_in_valid_i           <= 1'b1;
      exp_beat_mem[tx_wr]          <= value[15:0];
      exp_beat_mem[tx_wr + 8'd1]   <= value[31:16];
      tx_wr                        <= tx_wr + 8'd2;
      do begin
        data_out_ready_i <= 1'(next_random());
        @(posedge clk_i);
      end while (!payload_in_ready_o);
    end
    payload_in_valid_i <= 1'b0;
    data_out_ready_i   <= 1'b0;
  endtask

  task automatic send_beats(input int count, input logic random_ready);
    for (int n = 0; n < count; n++) begin
      data_in_i       <= beat_t'(next_random());
      data_in_valid_i <= '1;
      do begin
        payload_out_ready_i <= random_ready ? 1'(next_random()) : 1'b0;
        @(posedge clk_i);
      end while (data_in_ready_o != '1);
    end
    data_in_valid_i <= '0;
  endtask

  task automatic drain_payloads();
    while (rx_rd != rx_wr) begin
      payload_out_ready_i <= 1'(next_random());
      @(posedge clk_i);
    end
    payload_out_ready_i <= 1'b0;
  endtask

  task automatic drive_partial_valid();
    payload_out_ready_i <= 1'b1;
    for (int n = 0; n < 8; n++) begin
      data_in_i       <= beat_t'(next_random());
      data_in_valid_i <= n[0] ? 2'b10 : 2'b01;
      @(posedge clk_i);
    end
    data_in_valid_i     <= '0;
    payload_out_ready_i <= 1'b0;
    @(posedge clk_i);
  endtask

  task automatic push_raw_bytes(input int count);
    for (int n = 0; n < count; n++) begin
      raw_out_data_i  <= phy_data_t'(next_random());
      raw_out_valid_i <= 1'b1;
      @(posedge clk_i);
    end
    raw_out_valid_i <= 1'b0;
  endtask

  task automatic run_raw_transmit();
    raw_mode_en_i    <= 1'b1;
    raw_out_en_i     <= 1'b0;
    data_out_ready_i <= 1'b0;
    @(posedge clk_i);
    // One more than the depth, the last byte must be dropped
    push_raw_bytes(RAW_DEPTH + 1);
    raw_out_en_i <= 1'b1;
    for (int n = 0; n < N_RAW_MIX; n++) begin
      raw_out_ch_mask_i <= chan_mask_t'(next_random());
      data_out_ready_i  <= 1'(next_random());
      raw_out_valid_i   <= 1'(next_random());
      raw_out_data_i    <= phy_data_t'(next_random());
      @(posedge clk_i);
    end
    raw_out_valid_i  <= 1'b0;
    data_out_ready_i <= 1'b1;
    @(posedge clk_i);
    while (raw_wr != raw_rd) begin
      @(posedge clk_i);
    end
    // Bytes pushed before a clear must never reach the channels
    raw_out_en_i     <= 1'b0;
    data_out_ready_i <= 1'b0;
    push_raw_bytes(3);
    raw_fifo_clear_i <= 1'b1;
    @(posedge clk_i);
    raw_fifo_clear_i <= 1'b0;
    raw_out_en_i     <= 1'b1;
    data_out_ready_i <= 1'b1;
    repeat (4) @(posedge clk_i);
    raw_out_en_i     <= 1'b0;
    data_out_ready_i <= 1'b0;
  endtask

  task automatic run_raw_receive();
    for (int n = 0; n < N_RAW_RX; n++) begin
      raw_in_ch_sel_i <= chan_sel_t'(next_random());
      data_in_i       <= beat_t'(next_random());
      data_in_valid_i <= chan_mask_t'(next_random());
      raw_in_ready_i  <= 1'(next_random());
      @(posedge clk_i);
    end
    data_in_valid_i <= '0;
    raw_in_ready_i  <= 1'b0;
    raw_mode_en_i   <= 1'b0;
    @(posedge clk_i);
  endtask

  task automatic run_recv_clear();
    // Three beats stuck behind a stalled payload
    send_beats(3, 1'b0);
    recv_fifo_clear_i <= 1'b1;
    @(posedge clk_i);
    recv_fifo_clear_i <= 1'b0;
    @(posedge clk_i);
    send_beats(2, 1'b1);
    drain_payloads();
  endtask

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("Watchdog expired: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    stop_with_failure();
  end

  initial begin
    rst_n_i             = 1'b0;
    payload_in_i        = '0;
    payload_in_valid_i  = 1'b0;
    payload_out_ready_i = 1'b0;
    data_out_ready_i    = 1'b0;
    data_in_i           = '0;
    data_in_valid_i     = '0;
    raw_mode_en_i       = 1'b0;
    recv_fifo_clear_i   = 1'b0;
    raw_in_ch_sel_i     = '0;
    raw_in_ready_i      = 1'b0;
    raw_out_ch_mask_i   = '0;
    raw_out_data_i      = '0;
    raw_out_valid_i     = 1'b0;
    raw_out_en_i        = 1'b0;
    raw_fifo_clear_i    = 1'b0;
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);

    send_payloads(N_TX_PAYLOADS);
    send_beats(2 * N_RX_PAYLOADS, 1'b1);
    drain_payloads();
    drive_partial_valid();
    run_raw_transmit();
    run_raw_receive();
    run_recv_clear();

    repeat (4) @(posedge clk_i);
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+hdl
hdl/serial_link_pkg.sv
hdl/serial_link_tx_split.sv
hdl/serial_link_rx_assemble.sv
hdl/serial_link_raw_fifo.sv
hdl/serial_link_data_link.sv
tb/tb_serial_link_data_link.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the data link testbench with Verilator
set -e
cd "$(dirname "$0")"

TOP=tb_serial_link_data_link
LOG=sim.log

verilator --binary --assert --top-module "$TOP" -f list.f
./obj_dir/V"$TOP" 2>&1 | tee "$LOG"

if grep -qF "** FAIL **" "$LOG"; then
  echo "Simulation failed, see $LOG"
  exit 1
fi
if ! grep -qF "** PASS **" "$LOG"; then
  echo "Simulation ended without a result, see $LOG"
  exit 1
fi
echo "Simulation passed"
